//--- common/mmu_pkg.sv
package mmu_pkg;

    // TLB geometry
    localparam int tlb_entries   = 16;
    localparam int tlb_index_w   = 4;
    localparam int vpn2_w        = 19;
    localparam int asid_w        = 8;
    localparam int pfn_w         = 20;
    localparam int cache_attr_w  = 3;
    localparam int page_offset_w = 12;
    localparam int word_w        = 32;

    // Random restarts at the top entry
    localparam logic [tlb_index_w-1:0] random_reset = 4'd15;

    // coprocessor register numbers
    localparam int cp0_addr_w = 5;
    localparam logic [cp0_addr_w-1:0] cp0_reg_index    = 5'd0;
    localparam logic [cp0_addr_w-1:0] cp0_reg_random   = 5'd1;
    localparam logic [cp0_addr_w-1:0] cp0_reg_entrylo0 = 5'd2;
    localparam logic [cp0_addr_w-1:0] cp0_reg_entrylo1 = 5'd3;
    localparam logic [cp0_addr_w-1:0] cp0_reg_entryhi  = 5'd10;

    // one mtc0/mfc0 word, seen as EntryHi or as EntryLo
    typedef union packed {
        logic [word_w-1:0] raw;
        struct packed {
            logic [vpn2_w-1:0] vpn2;
            logic [4:0]        rsvd;
            logic [asid_w-1:0] asid;
        } hi;
        struct packed {
            logic [5:0]              rsvd;
            logic [pfn_w-1:0]        pfn;
            logic [cache_attr_w-1:0] c;
            logic                    d;
            logic                    v;
            logic                    g;
        } lo;
    } cp0_word_u;

endpackage

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic aclk,
    output logic reset
);

    // 8 unit period
    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge aclk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- dv/tb_mmu.sv
module tb_mmu;

    localparam int op_wi = 0;
    localparam int op_wr = 1;
    localparam int op_p  = 2;
    localparam int n_rounds = 4;
    localparam int n_wi     = 24;
    localparam int n_asid   = 4;
    localparam int n_wr     = 20;
    localparam int n_probe  = 16;
    // cycles per test: a write or TLB op is 3, a read or lookup is 1
    localparam int test_cycles = 13 + n_rounds * 20 + n_wi * 18 + n_asid * 20
                               + n_wr * 15 + n_probe * 7;
    localparam int timeout_cycles = test_cycles + 100;

    logic        aclk;
    logic        reset;
    logic        cp0_wen;
    logic [4:0]  cp0_waddr;
    logic [31:0] cp0_wdata;
    logic [4:0]  cp0_raddr;
    logic [31:0] cp0_rdata;
    logic        tlbwi;
    logic        tlbwr;
    logic        tlbp;
    logic [31:0] inst_vaddr;
    logic [31:0] inst_paddr;
    logic        inst_found;
    logic        inst_valid;
    logic [31:0] data_vaddr;
    logic [31:0] data_paddr;
    logic        data_found;
    logic        data_valid;
    logic        data_dirty;

    // reference model state
    logic [18:0] m_vpn2 [16];
    logic [7:0]  m_asid [16];
    logic        m_g    [16];
    logic [19:0] m_pfn0 [16];
    logic [19:0] m_pfn1 [16];
    logic        m_v0   [16];
    logic        m_v1   [16];
    logic        m_d0   [16];
    logic        m_d1   [16];
    logic        m_index_p;
    logic [3:0]  m_index;
    logic [3:0]  m_random;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    logic [31:0] m_hi;

    logic [31:0] rng_state = 32'hc7c6_250e;
    int          checks = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          cycle_count = 0;
    logic [4:0]  reg_list [5];
    logic [31:0] r;
    logic [31:0] lo0_word;
    logic [31:0] lo1_word;
    logic [3:0]  idx;
    logic [18:0] vpn2;
    logic [18:0] old_vpn2;
    logic [7:0]  asid;
    logic        glob;

    tb_clock_gen clk_gen (
        .aclk(aclk),
        .reset(reset)
    );

    tlb_mmu_top uut (
        .aclk(aclk), .reset(reset),
        .cp0_wen(cp0_wen), .cp0_waddr(cp0_waddr), .cp0_wdata(cp0_wdata),
        .cp0_raddr(cp0_raddr), .cp0_rdata(cp0_rdata),
        .tlbwi(tlbwi), .tlbwr(tlbwr), .tlbp(tlbp),
        .inst_vaddr(inst_vaddr), .inst_paddr(inst_paddr),
        .inst_found(inst_found), .inst_valid(inst_valid),
        .data_vaddr(data_vaddr), .data_paddr(data_paddr),
        .data_found(data_found), .data_valid(data_valid), .data_dirty(data_dirty)
    );

    // swap halves so the low result bits come from the better LCG bits
    function automatic logic [31:0] rand32();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    function automatic string reg_name(input logic [4:0] addr);
        case (addr)
            mmu_pkg::cp0_reg_index:    return "cp0_rdata(index)";
            mmu_pkg::cp0_reg_random:   return "cp0_rdata(random)";
            mmu_pkg::cp0_reg_entrylo0: return "cp0_rdata(entrylo0)";
            mmu_pkg::cp0_reg_entrylo1: return "cp0_rdata(entrylo1)";
            default:                   return "cp0_rdata(entryhi)";
        endcase
    endfunction

    function automatic logic [31:0] expected_reg(input logic [4:0] addr);
        case (addr)
            mmu_pkg::cp0_reg_index:    return {m_index_p, 27'd0, m_index};
            mmu_pkg::cp0_reg_random:   return {28'd0, m_random};
            mmu_pkg::cp0_reg_entrylo0: return m_lo0;
            mmu_pkg::cp0_reg_entrylo1: return m_lo1;
            mmu_pkg::cp0_reg_entryhi:  return m_hi;
            default:                   return 32'd0;
        endcase
    endfunction

    // an entry needs at least one valid page to take part in a match
    function automatic logic entry_hits(input int i, input logic [18:0] va_vpn2);
        return (m_vpn2[i] == va_vpn2) && (m_g[i] || m_asid[i] == m_hi[7:0])
            && (m_v0[i] || m_v1[i]);
    endfunction

    task automatic model_lookup(input logic [31:0] va, output logic f,
                                output logic [31:0] pa, output logic v, output logic d);
        f = 1'b0;
        pa = 32'd0;
        v = 1'b0;
        d = 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (entry_hits(i, va[31:13])) begin
                f = 1'b1;
                pa = va[12] ? {m_pfn1[i], va[11:0]} : {m_pfn0[i], va[11:0]};
                v = va[12] ? m_v1[i] : m_v0[i];
                d = va[12] ? m_d1[i] : m_d0[i];
            end
        end
    endtask

    task automatic model_write_entry(input logic [3:0] i);
        m_vpn2[i] = m_hi[31:13];
        m_asid[i] = m_hi[7:0];
        m_g[i]    = m_lo0[0] & m_lo1[0];
        m_v0[i]   = m_lo0[1];
        m_d0[i]   = m_lo0[2];
        m_pfn0[i] = m_lo0[25:6];
        m_v1[i]   = m_lo1[1];
        m_d1[i]   = m_lo1[2];
        m_pfn1[i] = m_lo1[25:6];
    endtask

    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic cp0_write(input logic [4:0] addr, input logic [31:0] data);
        cp0_wen = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        step();
        cp0_wen = 1'b0;
        step();
        step();
        case (addr)
            mmu_pkg::cp0_reg_index:    m_index = data[3:0];
            mmu_pkg::cp0_reg_entrylo0: m_lo0 = data & 32'h03ff_ffff;
            mmu_pkg::cp0_reg_entrylo1: m_lo1 = data & 32'h03ff_ffff;
            mmu_pkg::cp0_reg_entryhi:  m_hi = data & 32'hffff_e0ff;
            default: ;
        endcase
    endtask

    task automatic check_reg(input logic [4:0] addr);
        cp0_raddr = addr;
        step();
        check_word(reg_name(addr), cp0_rdata, expected_reg(addr));
    endtask

    task automatic tlb_op(input int op);
        logic hit;
        tlbwi = (op == op_wi);
        tlbwr = (op == op_wr);
        tlbp = (op == op_p);
        step();
        tlbwi = 1'b0;
        tlbwr = 1'b0;
        tlbp = 1'b0;
        step();
        step();
        if (op == op_wi) begin
            model_write_entry(m_index);
        end else if (op == op_wr) begin
            model_write_entry(m_random);
            m_random = (m_random == 4'd0) ? 4'd15 : m_random - 4'd1;
        end else begin
            hit = 1'b0;
            for (int i = 0; i < 16; i++) begin
                if (entry_hits(i, m_hi[31:13])) begin
                    hit = 1'b1;
                    m_index = i[3:0];
                end
            end
            m_index_p = !hit;
        end
    endtask

    // both ports take an address in the same cycle, results follow one edge later
    task automatic check_lookup(input logic [31:0] iva, input logic [31:0] dva);
        logic        i_found;
        logic [31:0] i_paddr;
        logic        i_valid;
        logic        i_dirty;
        logic        d_found;
        logic [31:0] d_paddr;
        logic        d_valid;
        logic        d_dirty;
        model_lookup(iva, i_found, i_paddr, i_valid, i_dirty);
        model_lookup(dva, d_found, d_paddr, d_valid, d_dirty);
        inst_vaddr = iva;
        data_vaddr = dva;
        step();
        check_bit("inst_found", inst_found, i_found);
        check_bit("inst_valid", inst_valid, i_valid);
        if (i_found) begin
            check_word("inst_paddr", inst_paddr, i_paddr);
        end
        check_bit("data_found", data_found, d_found);
        check_bit("data_valid", data_valid, d_valid);
        check_bit("data_dirty", data_dirty, d_dirty);
        if (d_found) begin
            check_word("data_paddr", data_paddr, d_paddr);
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic write_entry_regs(input logic [18:0] v2, input logic [31:0] hi_low,
                                    input logic [31:0] lo0, input logic [31:0] lo1);
        cp0_write(mmu_pkg::cp0_reg_entryhi, {v2, hi_low[12:0]});
        cp0_write(mmu_pkg::cp0_reg_entrylo0, lo0);
        cp0_write(mmu_pkg::cp0_reg_entrylo1, lo1);
    endtask

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        cp0_wen = 1'b0;
        cp0_waddr = 5'd0;
        cp0_wdata = 32'd0;
        cp0_raddr = 5'd0;
        tlbwi = 1'b0;
        tlbwr = 1'b0;
        tlbp = 1'b0;
        inst_vaddr = 32'd0;
        data_vaddr = 32'd0;
        for (int i = 0; i < 16; i++) begin
            m_vpn2[i] = 19'd0;
            m_asid[i] = 8'd0;
            m_pfn0[i] = 20'd0;
            m_pfn1[i] = 20'd0;
            m_g[i] = 1'b0;
            m_v0[i] = 1'b0;
            m_v1[i] = 1'b0;
            m_d0[i] = 1'b0;
            m_d1[i] = 1'b0;
        end
        m_index_p = 1'b0;
        m_index = 4'd0;
        m_random = 4'd15;
        m_lo0 = 32'd0;
        m_lo1 = 32'd0;
        m_hi = 32'd0;
        reg_list[0] = mmu_pkg::cp0_reg_index;
        reg_list[1] = mmu_pkg::cp0_reg_random;
        reg_list[2] = mmu_pkg::cp0_reg_entrylo0;
        reg_list[3] = mmu_pkg::cp0_reg_entrylo1;
        reg_list[4] = mmu_pkg::cp0_reg_entryhi;
        @(negedge reset);
        step();

        for (int k = 0; k < 5; k++) begin
            check_reg(reg_list[k]);
        end
        for (int k = 0; k < 8; k++) begin
            check_lookup(rand32(), rand32());
        end
        end_test(1, "reset state");

        // reserved bits and the Random register ignore writes
        for (int n = 0; n < n_rounds; n++) begin
            for (int k = 0; k < 5; k++) begin
                cp0_write(reg_list[k], rand32());
                check_reg(reg_list[k]);
            end
        end
        end_test(2, "register access");

        for (int n = 0; n < n_wi; n++) begin
            r = rand32();
            idx = r[3:0];
            vpn2 = {r[18:4], idx};
            cp0_write(mmu_pkg::cp0_reg_index, {rand32() & 32'hffff_fff0} | {28'd0, idx});
            write_entry_regs(vpn2, rand32(), rand32(), rand32());
            tlb_op(op_wi);
            r = rand32();
            check_lookup({vpn2, 1'b0, r[11:0]}, {vpn2, 1'b1, r[23:12]});
            check_lookup({vpn2, 1'b1, r[11:0]}, {vpn2, 1'b0, r[23:12]});
            check_lookup(rand32(), {vpn2, r[12:0]});
        end
        end_test(3, "tlbwi and lookup");

        for (int n = 0; n < n_asid; n++) begin
            r = rand32();
            idx = r[3:0];
            vpn2 = {r[18:4], idx};
            asid = r[27:20];
            glob = n[0];
            lo0_word = rand32();
            lo1_word = rand32();
            lo0_word[1:0] = {1'b1, glob};
            lo1_word[1:0] = {1'b1, glob};
            cp0_write(mmu_pkg::cp0_reg_index, {28'd0, idx});
            write_entry_regs(vpn2, {24'd0, asid}, lo0_word, lo1_word);
            tlb_op(op_wi);
            // switch to another address space
            cp0_write(mmu_pkg::cp0_reg_entryhi, {vpn2, 5'd0, asid ^ 8'h5a});
            check_lookup({vpn2, 1'b0, r[11:0]}, {vpn2, 1'b1, r[11:0]});
            check_bit("inst_found", inst_found, glob);
            check_bit("data_found", data_found, glob);
        end
        end_test(4, "asid and global");

        for (int n = 0; n < n_wr; n++) begin
            r = rand32();
            idx = m_random;
            vpn2 = {r[18:4], idx};
            old_vpn2 = m_vpn2[idx];
            lo0_word = rand32() | 32'h0000_0002;
            write_entry_regs(vpn2, rand32(), lo0_word, rand32());
            tlb_op(op_wr);
            check_reg(mmu_pkg::cp0_reg_random);
            check_lookup({vpn2, 1'b0, r[31:20]}, {vpn2, 1'b1, r[31:20]});
            // the previous occupant of this slot must be gone
            check_lookup({old_vpn2, 1'b0, r[11:0]}, {old_vpn2, 1'b1, r[11:0]});
        end
        end_test(5, "tlbwr placement");

        for (int n = 0; n < n_probe; n++) begin
            r = rand32();
            idx = r[3:0];
            if (n[0] == 1'b0) begin
                cp0_write(mmu_pkg::cp0_reg_entryhi, {m_vpn2[idx], 5'd0, m_asid[idx]});
            end else begin
                cp0_write(mmu_pkg::cp0_reg_entryhi, {r[22:8], idx, r[12:0]});
            end
            tlb_op(op_p);
            check_reg(mmu_pkg::cp0_reg_index);
        end
        end_test(6, "tlbp");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- mmu/cp0_tlb_regs.sv
module cp0_tlb_regs (
    input  logic                              aclk,
    input  logic                              reset,
    input  logic                              cp0_wen,
    input  logic [mmu_pkg::cp0_addr_w-1:0]    cp0_waddr,
    input  logic [mmu_pkg::word_w-1:0]        cp0_wdata,
    input  logic [mmu_pkg::cp0_addr_w-1:0]    cp0_raddr,
    output logic [mmu_pkg::word_w-1:0]        cp0_rdata,
    input  logic                              tlbwi,
    input  logic                              tlbwr,
    input  logic                              tlbp,
    input  logic                              probe_found,
    input  logic [mmu_pkg::tlb_index_w-1:0]   probe_index,
    output logic [mmu_pkg::vpn2_w-1:0]        entryhi_vpn2,
    output logic [mmu_pkg::asid_w-1:0]        entryhi_asid,
    output logic                              entry_we,
    output logic [mmu_pkg::tlb_index_w-1:0]   entry_windex,
    output logic [mmu_pkg::pfn_w-1:0]         lo0_pfn,
    output logic [mmu_pkg::cache_attr_w-1:0]  lo0_c,
    output logic                              lo0_d,
    output logic                              lo0_v,
    output logic                              lo0_g,
    output logic [mmu_pkg::pfn_w-1:0]         lo1_pfn,
    output logic [mmu_pkg::cache_attr_w-1:0]  lo1_c,
    output logic                              lo1_d,
    output logic                              lo1_v,
    output logic                              lo1_g
);

    mmu_pkg::cp0_word_u               wword;
    mmu_pkg::cp0_word_u               rword;
    logic                             index_p;
    logic [mmu_pkg::tlb_index_w-1:0]  index_val;
    logic [mmu_pkg::tlb_index_w-1:0]  random;
    logic                             probe_pending;

    assign wword = cp0_wdata;

    // tlbwr uses Random, tlbwi uses Index
    assign entry_we     = tlbwi | tlbwr;
    assign entry_windex = tlbwr ? random : index_val;

    always_ff @(posedge aclk) begin
        if (reset) begin
            index_p       <= 1'b0;
            index_val     <= '0;
            random        <= mmu_pkg::random_reset;
            probe_pending <= 1'b0;
            entryhi_vpn2  <= '0;
            entryhi_asid  <= '0;
            {lo0_pfn, lo0_c, lo0_d, lo0_v, lo0_g} <= '0;
            {lo1_pfn, lo1_c, lo1_d, lo1_v, lo1_g} <= '0;
        end else begin
            probe_pending <= tlbp;
            if (tlbwr) begin
                random <= (random == '0) ? mmu_pkg::random_reset : random - 1'b1;
            end
            // Random and the probe bit are not software writable
            if (cp0_wen) begin
                case (cp0_waddr)
                    mmu_pkg::cp0_reg_index: index_val <= wword.raw[mmu_pkg::tlb_index_w-1:0];
                    mmu_pkg::cp0_reg_entrylo0: begin
                        lo0_pfn <= wword.lo.pfn;
                        lo0_c   <= wword.lo.c;
                        lo0_d   <= wword.lo.d;
                        lo0_v   <= wword.lo.v;
                        lo0_g   <= wword.lo.g;
                    end
                    mmu_pkg::cp0_reg_entrylo1: begin
                        lo1_pfn <= wword.lo.pfn;
                        lo1_c   <= wword.lo.c;
                        lo1_d   <= wword.lo.d;
                        lo1_v   <= wword.lo.v;
                        lo1_g   <= wword.lo.g;
                    end
                    mmu_pkg::cp0_reg_entryhi: begin
                        entryhi_vpn2 <= wword.hi.vpn2;
                        entryhi_asid <= wword.hi.asid;
                    end
                    default: ;
                endcase
            end
            // probe result is registered one edge after the strobe
            if (probe_pending) begin
                index_p <= !probe_found;
                if (probe_found) begin
                    index_val <= probe_index;
                end
            end
        end
    end

    always_comb begin
        rword.raw = '0;
        case (cp0_raddr)
            mmu_pkg::cp0_reg_index: begin
                rword.raw[mmu_pkg::word_w-1]          = index_p;
                rword.raw[mmu_pkg::tlb_index_w-1:0]   = index_val;
            end
            mmu_pkg::cp0_reg_random: rword.raw[mmu_pkg::tlb_index_w-1:0] = random;
            mmu_pkg::cp0_reg_entrylo0: begin
                rword.lo.pfn = lo0_pfn;
                rword.lo.c   = lo0_c;
                rword.lo.d   = lo0_d;
                rword.lo.v   = lo0_v;
                rword.lo.g   = lo0_g;
            end
            mmu_pkg::cp0_reg_entrylo1: begin
                rword.lo.pfn = lo1_pfn;
                rword.lo.c   = lo1_c;
                rword.lo.d   = lo1_d;
                rword.lo.v   = lo1_v;
                rword.lo.g   = lo1_g;
            end
            mmu_pkg::cp0_reg_entryhi: begin
                rword.hi.vpn2 = entryhi_vpn2;
                rword.hi.asid = entryhi_asid;
            end
            default: ;
        endcase
    end

    assign cp0_rdata = rword.raw;

    // mtc0 and the TLB operations never overlap
    a_strobes_exclusive: assert property (@(posedge aclk) disable iff (reset)
        $onehot0({cp0_wen, tlbwi, tlbwr, tlbp}));

    // Index belongs to the probe capture in the cycle after a tlbp
    a_probe_capture: assert property (@(posedge aclk) disable iff (reset)
        probe_pending |-> !tlbwi && !(cp0_wen && cp0_waddr == mmu_pkg::cp0_reg_index));

endmodule

//--- mmu/tlb_entry_array.sv
module tlb_entry_array (
    input  logic                                                  aclk,
    input  logic                                                  reset,
    input  logic                                                  entry_we,
    input  logic [mmu_pkg::tlb_index_w-1:0]                       entry_windex,
    input  logic [mmu_pkg::vpn2_w-1:0]                            entryhi_vpn2,
    input  logic [mmu_pkg::asid_w-1:0]                            entryhi_asid,
    input  logic [mmu_pkg::pfn_w-1:0]                             lo0_pfn,
    input  logic [mmu_pkg::cache_attr_w-1:0]                      lo0_c,
    input  logic                                                  lo0_d,
    input  logic                                                  lo0_v,
    input  logic                                                  lo0_g,
    input  logic [mmu_pkg::pfn_w-1:0]                             lo1_pfn,
    input  logic [mmu_pkg::cache_attr_w-1:0]                      lo1_c,
    input  logic                                                  lo1_d,
    input  logic                                                  lo1_v,
    input  logic                                                  lo1_g,
    output logic [mmu_pkg::tlb_entries*mmu_pkg::vpn2_w-1:0]       ent_vpn2,
    output logic [mmu_pkg::tlb_entries*mmu_pkg::asid_w-1:0]       ent_asid,
    output logic [mmu_pkg::tlb_entries-1:0]                       ent_g,
    output logic [mmu_pkg::tlb_entries*mmu_pkg::pfn_w-1:0]        ent_pfn0,
    output logic [mmu_pkg::tlb_entries*mmu_pkg::cache_attr_w-1:0] ent_c0,
    output logic [mmu_pkg::tlb_entries-1:0]                       ent_d0,
    output logic [mmu_pkg::tlb_entries-1:0]                       ent_v0,
    output logic [mmu_pkg::tlb_entries*mmu_pkg::pfn_w-1:0]        ent_pfn1,
    output logic [mmu_pkg::tlb_entries*mmu_pkg::cache_attr_w-1:0] ent_c1,
    output logic [mmu_pkg::tlb_entries-1:0]                       ent_d1,
    output logic [mmu_pkg::tlb_entries-1:0]                       ent_v1
);

    // entry payload
    always_ff @(posedge aclk) begin
        if (entry_we) begin
            ent_vpn2[entry_windex*mmu_pkg::vpn2_w +: mmu_pkg::vpn2_w]               <= entryhi_vpn2;
            ent_asid[entry_windex*mmu_pkg::asid_w +: mmu_pkg::asid_w]               <= entryhi_asid;
            ent_pfn0[entry_windex*mmu_pkg::pfn_w +: mmu_pkg::pfn_w]                 <= lo0_pfn;
            ent_pfn1[entry_windex*mmu_pkg::pfn_w +: mmu_pkg::pfn_w]                 <= lo1_pfn;
            ent_c0[entry_windex*mmu_pkg::cache_attr_w +: mmu_pkg::cache_attr_w]     <= lo0_c;
            ent_c1[entry_windex*mmu_pkg::cache_attr_w +: mmu_pkg::cache_attr_w]     <= lo1_c;
            ent_d0[entry_windex] <= lo0_d;
            ent_d1[entry_windex] <= lo1_d;
        end
    end

    // an entry is global only when both halves say so
    always_ff @(posedge aclk) begin
        if (reset) begin
            ent_g  <= '0;
            ent_v0 <= '0;
            ent_v1 <= '0;
        end else if (entry_we) begin
            ent_g[entry_windex]  <= lo0_g & lo1_g;
            ent_v0[entry_windex] <= lo0_v;
            ent_v1[entry_windex] <= lo1_v;
        end
    end

endmodule

//--- mmu/tlb_lookup_port.sv
module tlb_lookup_port (
    input  logic                                            aclk,
    input  logic                                            reset,
    input  logic [mmu_pkg::word_w-1:0]                      vaddr,
    input  logic [mmu_pkg::asid_w-1:0]                      asid,
    input  logic [mmu_pkg::tlb_entries*mmu_pkg::vpn2_w-1:0] ent_vpn2,
    input  logic [mmu_pkg::tlb_entries*mmu_pkg::asid_w-1:0] ent_asid,
    input  logic [mmu_pkg::tlb_entries-1:0]                 ent_g,
    input  logic [mmu_pkg::tlb_entries*mmu_pkg::pfn_w-1:0]  ent_pfn0,
    input  logic [mmu_pkg::tlb_entries-1:0]                 ent_d0,
    input  logic [mmu_pkg::tlb_entries-1:0]                 ent_v0,
    input  logic [mmu_pkg::tlb_entries*mmu_pkg::pfn_w-1:0]  ent_pfn1,
    input  logic [mmu_pkg::tlb_entries-1:0]                 ent_d1,
    input  logic [mmu_pkg::tlb_entries-1:0]                 ent_v1,
    output logic                                            found,
    output logic [mmu_pkg::tlb_index_w-1:0]                 index,
    output logic [mmu_pkg::word_w-1:0]                      paddr,
    output logic                                            valid,
    output logic                                            dirty
);

    logic [mmu_pkg::tlb_entries-1:0]  match;
    logic                             hit;
    logic [mmu_pkg::tlb_index_w-1:0]  hit_index;
    logic [mmu_pkg::pfn_w-1:0]        hit_pfn;
    logic                             hit_v;
    logic                             hit_d;
    logic                             odd;

    assign odd = vaddr[mmu_pkg::page_offset_w];

    // an entry with neither page valid is treated as empty
    for (genvar i = 0; i < mmu_pkg::tlb_entries; i++) begin : g_match
        assign match[i] =
            (ent_vpn2[i*mmu_pkg::vpn2_w +: mmu_pkg::vpn2_w] ==
             vaddr[mmu_pkg::word_w-1 -: mmu_pkg::vpn2_w]) &&
            (ent_g[i] || ent_asid[i*mmu_pkg::asid_w +: mmu_pkg::asid_w] == asid) &&
            (ent_v0[i] || ent_v1[i]);
    end

    always_comb begin
        hit       = 1'b0;
        hit_index = '0;
        hit_pfn   = '0;
        hit_v     = 1'b0;
        hit_d     = 1'b0;
        for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
            if (match[i]) begin
                hit       = 1'b1;
                hit_index = i[mmu_pkg::tlb_index_w-1:0];
                hit_pfn   = odd ? ent_pfn1[i*mmu_pkg::pfn_w +: mmu_pkg::pfn_w]
                                : ent_pfn0[i*mmu_pkg::pfn_w +: mmu_pkg::pfn_w];
                hit_v     = odd ? ent_v1[i] : ent_v0[i];
                hit_d     = odd ? ent_d1[i] : ent_d0[i];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            found <= 1'b0;
            valid <= 1'b0;
            dirty <= 1'b0;
        end else begin
            found <= hit;
            valid <= hit_v;
            dirty <= hit_d;
        end
    end

    always_ff @(posedge aclk) begin
        index <= hit_index;
        paddr <= {hit_pfn, vaddr[mmu_pkg::page_offset_w-1:0]};
    end

    // software never writes two entries for the same page pair
    a_single_match: assert property (@(posedge aclk) disable iff (reset)
        $onehot0(match));

endmodule

//--- mmu/tlb_mmu_top.sv
module tlb_mmu_top (
    input  logic                              aclk,
    input  logic                              reset,
    input  logic                              cp0_wen,
    input  logic [mmu_pkg::cp0_addr_w-1:0]    cp0_waddr,
    input  logic [mmu_pkg::word_w-1:0]        cp0_wdata,
    input  logic [mmu_pkg::cp0_addr_w-1:0]    cp0_raddr,
    output logic [mmu_pkg::word_w-1:0]        cp0_rdata,
    input  logic                              tlbwi,
    input  logic                              tlbwr,
    input  logic                              tlbp,
    input  logic [mmu_pkg::word_w-1:0]        inst_vaddr,
    output logic [mmu_pkg::word_w-1:0]        inst_paddr,
    output logic                              inst_found,
    output logic                              inst_valid,
    input  logic [mmu_pkg::word_w-1:0]        data_vaddr,
    output logic [mmu_pkg::word_w-1:0]        data_paddr,
    output logic                              data_found,
    output logic                              data_valid,
    output logic                              data_dirty
);

    localparam int n = mmu_pkg::tlb_entries;

    logic [mmu_pkg::vpn2_w-1:0]       entryhi_vpn2;
    logic [mmu_pkg::asid_w-1:0]       entryhi_asid;
    logic                             entry_we;
    logic [mmu_pkg::tlb_index_w-1:0]  entry_windex;
    logic [mmu_pkg::pfn_w-1:0]        lo0_pfn;
    logic [mmu_pkg::cache_attr_w-1:0] lo0_c;
    logic                             lo0_d;
    logic                             lo0_v;
    logic                             lo0_g;
    logic [mmu_pkg::pfn_w-1:0]        lo1_pfn;
    logic [mmu_pkg::cache_attr_w-1:0] lo1_c;
    logic                             lo1_d;
    logic                             lo1_v;
    logic                             lo1_g;
    logic                             probe_found;
    logic [mmu_pkg::tlb_index_w-1:0]  probe_index;

    // flattened entry fields, entry i at slice i
    logic [n*mmu_pkg::vpn2_w-1:0]     ent_vpn2;
    logic [n*mmu_pkg::asid_w-1:0]     ent_asid;
    logic [n-1:0]                     ent_g;
    logic [n*mmu_pkg::pfn_w-1:0]      ent_pfn0;
    logic [n-1:0]                     ent_d0;
    logic [n-1:0]                     ent_v0;
    logic [n*mmu_pkg::pfn_w-1:0]      ent_pfn1;
    logic [n-1:0]                     ent_d1;
    logic [n-1:0]                     ent_v1;

    cp0_tlb_regs u_regs (
        .aclk(aclk), .reset(reset),
        .cp0_wen(cp0_wen), .cp0_waddr(cp0_waddr), .cp0_wdata(cp0_wdata),
        .cp0_raddr(cp0_raddr), .cp0_rdata(cp0_rdata),
        .tlbwi(tlbwi), .tlbwr(tlbwr), .tlbp(tlbp),
        .probe_found(probe_found), .probe_index(probe_index),
        .entryhi_vpn2(entryhi_vpn2), .entryhi_asid(entryhi_asid),
        .entry_we(entry_we), .entry_windex(entry_windex),
        .lo0_pfn(lo0_pfn), .lo0_c(lo0_c), .lo0_d(lo0_d), .lo0_v(lo0_v), .lo0_g(lo0_g),
        .lo1_pfn(lo1_pfn), .lo1_c(lo1_c), .lo1_d(lo1_d), .lo1_v(lo1_v), .lo1_g(lo1_g)
    );

    // C fields are kept in the array but no lookup consumes them
    tlb_entry_array u_array (
        .aclk(aclk), .reset(reset),
        .entry_we(entry_we), .entry_windex(entry_windex),
        .entryhi_vpn2(entryhi_vpn2), .entryhi_asid(entryhi_asid),
        .lo0_pfn(lo0_pfn), .lo0_c(lo0_c), .lo0_d(lo0_d), .lo0_v(lo0_v), .lo0_g(lo0_g),
        .lo1_pfn(lo1_pfn), .lo1_c(lo1_c), .lo1_d(lo1_d), .lo1_v(lo1_v), .lo1_g(lo1_g),
        .ent_vpn2(ent_vpn2), .ent_asid(ent_asid), .ent_g(ent_g),
        .ent_pfn0(ent_pfn0), .ent_c0(), .ent_d0(ent_d0), .ent_v0(ent_v0),
        .ent_pfn1(ent_pfn1), .ent_c1(), .ent_d1(ent_d1), .ent_v1(ent_v1)
    );

    tlb_lookup_port u_inst_lookup (
        .aclk(aclk), .reset(reset), .vaddr(inst_vaddr), .asid(entryhi_asid),
        .ent_vpn2(ent_vpn2), .ent_asid(ent_asid), .ent_g(ent_g),
        .ent_pfn0(ent_pfn0), .ent_d0(ent_d0), .ent_v0(ent_v0),
        .ent_pfn1(ent_pfn1), .ent_d1(ent_d1), .ent_v1(ent_v1),
        .found(inst_found), .index(), .paddr(inst_paddr), .valid(inst_valid), .dirty()
    );

    tlb_lookup_port u_data_lookup (
        .aclk(aclk), .reset(reset), .vaddr(data_vaddr), .asid(entryhi_asid),
        .ent_vpn2(ent_vpn2), .ent_asid(ent_asid), .ent_g(ent_g),
        .ent_pfn0(ent_pfn0), .ent_d0(ent_d0), .ent_v0(ent_v0),
        .ent_pfn1(ent_pfn1), .ent_d1(ent_d1), .ent_v1(ent_v1),
        .found(data_found), .index(), .paddr(data_paddr), .valid(data_valid),
        .dirty(data_dirty)
    );

    // tlbp searches for EntryHi itself
    tlb_lookup_port u_probe_lookup (
        .aclk(aclk), .reset(reset),
        .vaddr({entryhi_vpn2, {(mmu_pkg::word_w - mmu_pkg::vpn2_w){1'b0}}}),
        .asid(entryhi_asid),
        .ent_vpn2(ent_vpn2), .ent_asid(ent_asid), .ent_g(ent_g),
        .ent_pfn0(ent_pfn0), .ent_d0(ent_d0), .ent_v0(ent_v0),
        .ent_pfn1(ent_pfn1), .ent_d1(ent_d1), .ent_v1(ent_v1),
        .found(probe_found), .index(probe_index), .paddr(), .valid(), .dirty()
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mmu -f tb.f -o tb_mmu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_mmu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- tb.f
common/mmu_pkg.sv
mmu/tlb_entry_array.sv
mmu/tlb_lookup_port.sv
mmu/cp0_tlb_regs.sv
mmu/tlb_mmu_top.sv
dv/tb_clock_gen.sv
dv/tb_mmu.sv
